// File: cpu.f
common/cpu_pkg.sv
fetch/stage_fetch.sv
verilog/stage_decode.sv
verilog/stage_execute.sv
verilog/cpu.sv
sim/tb_memory.sv
sim/cpu_tb.sv

// File: sim/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////
    // timing and limits
    //////////////////////////////////////////////////
    localparam int period          = 4;
    localparam int drive_delay     = 1;
    localparam int reset_cycles    = 4;
    // silent cycles required after the last commit
    localparam int quiet_cycles    = 20;
    localparam int image_words     = 64;
    // commits over all six programs
    localparam int total_insts     = 53;
    localparam int cycles_per_inst = 12;
    localparam int limit_ns        = total_insts * cycles_per_inst * period;
    // guard against a runaway reference program
    localparam int max_steps       = 200;

    typedef struct packed {
        logic [2:0]  idx;
        logic [31:0] data;
        logic        wr;
        logic [31:0] npc;
        logic [1:0]  status;
    } commit_t;

    logic                        clock;
    logic                        reset;
    mem_tag_t                    mem2proc_transaction_tag;
    logic [xlen-1:0]             mem2proc_data;
    mem_tag_t                    mem2proc_data_tag;
    mem_command_t                proc2mem_command;
    logic [xlen-1:0]             proc2mem_addr;
    logic [xlen-1:0]             proc2mem_data;
    logic [commit_cnt_width-1:0] pipeline_completed_insts;
    exception_code_t             pipeline_error_status;
    reg_idx_t                    pipeline_commit_wr_idx;
    logic [xlen-1:0]             pipeline_commit_wr_data;
    logic                        pipeline_commit_wr_en;
    logic [xlen-1:0]             pipeline_commit_NPC;

    // program under test for the memory model image
    logic [31:0] prog [image_words];
    commit_t     expected [$];
    string       test_name;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    cpu UUT (
        .clock                    (clock),
        .reset                    (reset),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .pipeline_completed_insts (pipeline_completed_insts),
        .pipeline_error_status    (pipeline_error_status),
        .pipeline_commit_wr_idx   (pipeline_commit_wr_idx),
        .pipeline_commit_wr_data  (pipeline_commit_wr_data),
        .pipeline_commit_wr_en    (pipeline_commit_wr_en),
        .pipeline_commit_NPC      (pipeline_commit_NPC)
    );

    tb_memory memory (
        .clock                    (clock),
        .reset                    (reset),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////
    // instruction encoding and programs
    //////////////////////////////////////////////////

    // opcode, rd, rs1, rs2, zero tail
    function automatic logic [31:0] r_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, rd, rs1, rs2, 19'h0};
    endfunction

    // opcode, rd, rs1, six reserved bits, imm
    function automatic logic [31:0] i_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, 6'h0, imm};
    endfunction

    task automatic clear_image();
        for (int i = 0; i < image_words; i++) begin
            // illegal opcode with the word index below it
            prog[i] = {4'hf, 22'h0, 6'(i)};
        end
    endtask

    task automatic arith_program();
        clear_image();
        prog[0] = i_word(op_addi, 3'd1, 3'd0, 16'd5);
        prog[1] = i_word(op_addi, 3'd2, 3'd0, 16'd9);
        prog[2] = r_word(op_add, 3'd3, 3'd1, 3'd2);
        prog[3] = r_word(op_sub, 3'd4, 3'd3, 3'd1);
        prog[4] = r_word(op_xor, 3'd5, 3'd3, 3'd2);
        // write to r0 is dropped
        prog[5] = r_word(op_add, 3'd0, 3'd1, 3'd2);
        prog[6] = r_word(op_add, 3'd6, 3'd0, 3'd1);
        prog[7] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
    endtask

    task automatic immediate_program();
        clear_image();
        prog[0] = i_word(op_addi, 3'd1, 3'd0, 16'hfffd);
        prog[1] = i_word(op_addi, 3'd2, 3'd1, 16'h8000);
        prog[2] = i_word(op_addi, 3'd3, 3'd2, 16'd100);
        prog[3] = i_word(op_addi, 3'd7, 3'd0, 16'h7fff);
        prog[4] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
    endtask

    task automatic branch_program();
        clear_image();
        prog[0]  = i_word(op_addi, 3'd1, 3'd0, 16'd7);
        prog[1]  = i_word(op_addi, 3'd2, 3'd0, 16'd7);
        // taken forward over the wrong-path words 3 and 4
        prog[2]  = i_word(op_beq, 3'd1, 3'd2, 16'd3);
        prog[3]  = i_word(op_addi, 3'd3, 3'd0, 16'd1);
        prog[4]  = i_word(op_addi, 3'd4, 3'd0, 16'd2);
        prog[5]  = i_word(op_addi, 3'd5, 3'd0, 16'd3);
        // not taken so execution falls through
        prog[6]  = i_word(op_beq, 3'd1, 3'd5, 16'd5);
        prog[7]  = i_word(op_addi, 3'd6, 3'd5, 16'd1);
        prog[8]  = i_word(op_beq, 3'd0, 3'd0, 16'd2);
        prog[9]  = i_word(op_addi, 3'd7, 3'd0, 16'd9);
        // backward branch loops until r3 reaches r1
        prog[10] = i_word(op_addi, 3'd3, 3'd3, 16'd1);
        prog[11] = i_word(op_beq, 3'd3, 3'd1, 16'd2);
        prog[12] = i_word(op_beq, 3'd0, 3'd0, 16'hfffe);
        prog[13] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
    endtask

    // chained results on a busy memory
    task automatic dependency_program();
        clear_image();
        prog[0] = i_word(op_addi, 3'd1, 3'd0, 16'd1);
        prog[1] = r_word(op_add, 3'd2, 3'd1, 3'd1);
        prog[2] = r_word(op_add, 3'd3, 3'd2, 3'd2);
        prog[3] = r_word(op_add, 3'd4, 3'd3, 3'd3);
        prog[4] = r_word(op_sub, 3'd5, 3'd4, 3'd1);
        prog[5] = r_word(op_xor, 3'd6, 3'd5, 3'd2);
        prog[6] = r_word(op_add, 3'd7, 3'd6, 3'd7);
        prog[7] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
    endtask

    task automatic halt_program();
        clear_image();
        prog[0] = i_word(op_addi, 3'd1, 3'd0, 16'd3);
        prog[1] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
        prog[2] = i_word(op_addi, 3'd2, 3'd0, 16'd4);
        prog[3] = i_word(op_addi, 3'd3, 3'd0, 16'd5);
    endtask

    task automatic illegal_program();
        clear_image();
        prog[0] = i_word(op_addi, 3'd1, 3'd0, 16'd2);
        prog[1] = 32'h9000_0000;
        prog[2] = i_word(op_addi, 3'd2, 3'd0, 16'd5);
        prog[3] = r_word(op_halt, 3'd0, 3'd0, 3'd0);
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    task automatic predict_commits();
        logic [31:0] regs [8];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] word;
        logic [31:0] imm;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic        done;
        int          steps;
        commit_t     c;
        expected.delete();
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        pc    = reset_pc;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < max_steps) begin
            word     = prog[pc[7:2]];
            op       = word[31:28];
            rd       = word[27:25];
            rs1      = word[24:22];
            rs2      = word[21:19];
            imm      = {{16{word[15]}}, word[15:0]};
            next_pc  = pc + 32'd4;
            c.idx    = rd;
            c.data   = '0;
            c.wr     = 1'b0;
            c.npc    = pc + 32'd4;
            c.status = no_error;
            case (op)
                op_add: {c.wr, c.data} = {1'b1, regs[rs1] + regs[rs2]};
                op_sub: {c.wr, c.data} = {1'b1, regs[rs1] - regs[rs2]};
                op_xor: {c.wr, c.data} = {1'b1, regs[rs1] ^ regs[rs2]};
                op_addi: {c.wr, c.data} = {1'b1, regs[rs1] + imm};
                // target counts in words from the branch itself
                op_beq: begin
                    if (regs[rd] == regs[rs1]) begin
                        next_pc = pc + (imm << 2);
                    end
                end
                op_halt: begin
                    c.status = halted_on_halt;
                    done     = 1'b1;
                end
                default: begin
                    c.status = illegal_inst;
                    done     = 1'b1;
                end
            endcase
            // r0 never changes
            if (rd == 3'd0) begin
                c.wr = 1'b0;
            end
            if (c.wr) begin
                regs[rd] = c.data;
            end
            expected.push_back(c);
            pc = next_pc;
            steps++;
        end
    endtask

    //////////////////////////////////////////////////
    // commit checker
    //////////////////////////////////////////////////
    task automatic report_mismatch(input string what, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("mismatch in %s: %s expected %h actual %h", test_name, what, want, got);
        test_errors++;
    endtask

    // registered outputs are stable at the falling edge
    always @(negedge clock) begin : commit_check
        commit_t want;
        // no stores, so write data stays zero
        if (!reset) begin
            assert (proc2mem_data == '0) else
                report_mismatch("proc2mem_data", 32'h0, proc2mem_data);
        end
        if (!reset && pipeline_completed_insts != '0) begin
            assert (pipeline_completed_insts == commit_cnt_width'(1)) else begin
                $display("error in %s: more than one instruction retired at once", test_name);
                test_errors++;
            end
            assert (expected.size() != 0) else begin
                $display("error in %s: an instruction retired after the program ended",
                         test_name);
                test_errors++;
            end
            if (expected.size() != 0) begin
                want = expected.pop_front();
                assert (pipeline_commit_NPC == want.npc) else
                    report_mismatch("npc", want.npc, pipeline_commit_NPC);
                assert (pipeline_error_status == want.status) else
                    report_mismatch("status", 32'(want.status), 32'(pipeline_error_status));
                assert (pipeline_commit_wr_en == want.wr) else
                    report_mismatch("wr_en", 32'(want.wr), 32'(pipeline_commit_wr_en));
                // index and data only count with a write
                if (want.wr) begin
                    assert (pipeline_commit_wr_idx == want.idx) else
                        report_mismatch("wr_idx", 32'(want.idx), 32'(pipeline_commit_wr_idx));
                    assert (pipeline_commit_wr_data == want.data) else
                        report_mismatch("wr_data", want.data, pipeline_commit_wr_data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    task automatic run_program(input string name, input int refuse);
        @(posedge clock);
        #drive_delay;
        reset = 1'b1;
        // image and model set up while the memory sits in reset
        @(negedge clock);
        test_name         = name;
        test_errors       = 0;
        memory.refuse_pct = refuse;
        for (int i = 0; i < image_words; i++) begin
            memory.image[i] = prog[i];
        end
        predict_commits();
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        reset = 1'b0;
        while (expected.size() != 0) begin
            @(posedge clock);
        end
        // nothing may retire after halt or illegal
        repeat (quiet_cycles) @(posedge clock);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s finished with no errors", name);
        end else begin
            fail_count++;
            $display("test %s finished with %0d errors", name, test_errors);
        end
    endtask

    initial begin : main
        reset       = 1'b1;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        test_name   = "none";
        arith_program();
        run_program("arith", 25);
        immediate_program();
        run_program("immediate", 25);
        branch_program();
        run_program("branch", 25);
        dependency_program();
        run_program("busy_memory", 60);
        halt_program();
        run_program("halt", 25);
        illegal_program();
        run_program("illegal", 25);
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(limit_ns);
        $display("timeout after %0d ns, the programs did not all finish", limit_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim/tb_memory.sv
module tb_memory import cpu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  mem_command_t    proc2mem_command,
    input  logic [xlen-1:0] proc2mem_addr,
    output mem_tag_t        mem2proc_transaction_tag,
    output logic [xlen-1:0] mem2proc_data,
    output mem_tag_t        mem2proc_data_tag
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int image_words = 64;
    localparam int drive_delay = 1;
    localparam int max_latency = 6;

    // program image, loaded by the testbench during reset
    logic [xlen-1:0] image [image_words];
    // chance in percent that a load is refused
    int              refuse_pct;
    integer          seed;
    mem_tag_t        next_tag;
    // loads in flight, oldest first
    int              cycles_left [$];
    mem_tag_t        flight_tag [$];
    logic [xlen-1:0] flight_data [$];

    function automatic int random_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    //////////////////////////////////////////////////
    // request and response process
    //////////////////////////////////////////////////
    initial begin : serve
        seed                     = 32'hf43f_ad7b;
        refuse_pct               = 25;
        next_tag                 = 4'd1;
        mem2proc_transaction_tag = '0;
        mem2proc_data            = '0;
        mem2proc_data_tag        = '0;
        forever begin
            @(posedge clock);
            if (reset) begin
                // drop anything still in flight
                cycles_left.delete();
                flight_tag.delete();
                flight_data.delete();
                next_tag = 4'd1;
                #drive_delay;
                mem2proc_transaction_tag = '0;
                mem2proc_data            = '0;
                mem2proc_data_tag        = '0;
            end else begin
                #drive_delay;
                // response valid for one cycle only
                mem2proc_data     = '0;
                mem2proc_data_tag = '0;
                foreach (cycles_left[i]) begin
                    cycles_left[i]--;
                end
                if (cycles_left.size() != 0 && cycles_left[0] <= 0) begin
                    mem2proc_data_tag = flight_tag.pop_front();
                    mem2proc_data     = flight_data.pop_front();
                    void'(cycles_left.pop_front());
                end
                // zero tag means busy
                mem2proc_transaction_tag = '0;
                if (proc2mem_command == mem_load && random_below(100) >= refuse_pct) begin
                    mem2proc_transaction_tag = next_tag;
                    flight_tag.push_back(next_tag);
                    flight_data.push_back(image[proc2mem_addr[7:2]]);
                    cycles_left.push_back(1 + random_below(max_latency));
                    // tags rotate through 1 to 15, never zero
                    next_tag = (next_tag == 4'hf) ? 4'd1 : next_tag + 4'd1;
                end
            end
        end
    end

endmodule

// File: verilog/cpu.sv
module cpu import cpu_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  mem_tag_t                    mem2proc_transaction_tag,
    input  logic [xlen-1:0]             mem2proc_data,
    input  mem_tag_t                    mem2proc_data_tag,
    output mem_command_t                proc2mem_command,
    output logic [xlen-1:0]             proc2mem_addr,
    output logic [xlen-1:0]             proc2mem_data,
    output logic [commit_cnt_width-1:0] pipeline_completed_insts,
    output exception_code_t             pipeline_error_status,
    output reg_idx_t                    pipeline_commit_wr_idx,
    output logic [xlen-1:0]             pipeline_commit_wr_data,
    output logic                        pipeline_commit_wr_en,
    output logic [xlen-1:0]             pipeline_commit_NPC
);

    //////////////////////////////////////////////////
    // stage wires
    //////////////////////////////////////////////////

    // fetch to decode
    logic            fetch_valid;
    logic [xlen-1:0] fetch_pc;
    inst_word_t      fetch_word;

    // decode to execute
    logic            dec_valid;
    logic [xlen-1:0] dec_pc;
    opcode_t         dec_opcode;
    reg_idx_t        dec_rd;
    reg_idx_t        dec_rs1;
    reg_idx_t        dec_rs2;
    logic [xlen-1:0] dec_imm;
    logic            dec_illegal;

    // execute back to the front end
    logic            squash;
    logic [xlen-1:0] redirect_pc;
    logic            halted;

    // no stores, nothing to write
    assign proc2mem_data = '0;

    stage_fetch fetch (
        .clock                    (clock),
        .reset                    (reset),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .squash                   (squash),
        .redirect_pc              (redirect_pc),
        .halted                   (halted),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .fetch_valid              (fetch_valid),
        .fetch_pc                 (fetch_pc),
        .fetch_word               (fetch_word)
    );

    stage_decode decode (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_word  (fetch_word),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_opcode  (dec_opcode),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm),
        .dec_illegal (dec_illegal)
    );

    // commit ports come straight from the execute registers
    stage_execute execute (
        .clock                    (clock),
        .reset                    (reset),
        .dec_valid                (dec_valid),
        .dec_pc                   (dec_pc),
        .dec_opcode               (dec_opcode),
        .dec_rd                   (dec_rd),
        .dec_rs1                  (dec_rs1),
        .dec_rs2                  (dec_rs2),
        .dec_imm                  (dec_imm),
        .dec_illegal              (dec_illegal),
        .squash                   (squash),
        .redirect_pc              (redirect_pc),
        .halted                   (halted),
        .pipeline_completed_insts (pipeline_completed_insts),
        .pipeline_error_status    (pipeline_error_status),
        .pipeline_commit_wr_idx   (pipeline_commit_wr_idx),
        .pipeline_commit_wr_data  (pipeline_commit_wr_data),
        .pipeline_commit_wr_en    (pipeline_commit_wr_en),
        .pipeline_commit_NPC      (pipeline_commit_NPC)
    );

endmodule

// File: verilog/stage_execute.sv
module stage_execute import cpu_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        dec_valid,
    input  logic [xlen-1:0]             dec_pc,
    input  opcode_t                     dec_opcode,
    input  reg_idx_t                    dec_rd,
    input  reg_idx_t                    dec_rs1,
    input  reg_idx_t                    dec_rs2,
    input  logic [xlen-1:0]             dec_imm,
    input  logic                        dec_illegal,
    output logic                        squash,
    output logic [xlen-1:0]             redirect_pc,
    output logic                        halted,
    output logic [commit_cnt_width-1:0] pipeline_completed_insts,
    output exception_code_t             pipeline_error_status,
    output reg_idx_t                    pipeline_commit_wr_idx,
    output logic [xlen-1:0]             pipeline_commit_wr_data,
    output logic                        pipeline_commit_wr_en,
    output logic [xlen-1:0]             pipeline_commit_NPC
);

    logic [xlen-1:0] regs [reg_count];
    logic [xlen-1:0] val_rd;
    logic [xlen-1:0] val_rs1;
    logic [xlen-1:0] val_rs2;
    logic [xlen-1:0] result;
    logic [xlen-1:0] target;
    logic            writes;
    logic            is_halt;
    logic            taken;
    logic            accept;
    exception_code_t status;

    //////////////////////////////////////////////////
    // register file read and alu
    //////////////////////////////////////////////////

    // r0 always reads zero
    assign val_rd  = (dec_rd == '0) ? '0 : regs[dec_rd];
    assign val_rs1 = (dec_rs1 == '0) ? '0 : regs[dec_rs1];
    assign val_rs2 = (dec_rs2 == '0) ? '0 : regs[dec_rs2];

    // word offset, relative to the branch itself
    assign target = dec_pc + {dec_imm[xlen-3:0], 2'b00};

    // instruction behind a taken branch or after halt is dropped
    assign accept = dec_valid && !squash && !halted;

    always_comb begin
        result  = '0;
        writes  = 1'b0;
        is_halt = 1'b0;
        taken   = 1'b0;
        if (!dec_illegal) begin
            case (dec_opcode)
                op_add: begin
                    result = val_rs1 + val_rs2;
                    writes = 1'b1;
                end
                op_sub: begin
                    result = val_rs1 - val_rs2;
                    writes = 1'b1;
                end
                op_xor: begin
                    result = val_rs1 ^ val_rs2;
                    writes = 1'b1;
                end
                op_addi: begin
                    result = val_rs1 + dec_imm;
                    writes = 1'b1;
                end
                // compares rd against rs1
                op_beq: taken = (val_rd == val_rs1);
                op_halt: is_halt = 1'b1;
                default: result = '0;
            endcase
        end
        status = dec_illegal ? illegal_inst : (is_halt ? halted_on_halt : no_error);
    end

    // writes to r0 are dropped here
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && writes && (dec_rd != '0)) begin
            regs[dec_rd] <= result;
        end
    end

    //////////////////////////////////////////////////
    // commit
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            squash                   <= 1'b0;
            halted                   <= 1'b0;
            pipeline_completed_insts <= '0;
            pipeline_commit_wr_en    <= 1'b0;
        end else begin
            // one-cycle pulse, the next cycle is always ignored
            squash                   <= accept && taken;
            halted                   <= halted || (accept && (is_halt || dec_illegal));
            pipeline_completed_insts <= accept ? commit_cnt_width'(1) : '0;
            pipeline_commit_wr_en    <= accept && writes && (dec_rd != '0);
        end
    end

    // commit payload, meaningful only with a commit
    always_ff @(posedge clock) begin
        redirect_pc             <= target;
        pipeline_error_status   <= status;
        pipeline_commit_wr_idx  <= dec_rd;
        pipeline_commit_wr_data <= result;
        pipeline_commit_NPC     <= dec_pc + 32'd4;
    end

endmodule

// File: verilog/stage_decode.sv
module stage_decode import cpu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            squash,
    input  logic            fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  inst_word_t      fetch_word,
    output logic            dec_valid,
    output logic [xlen-1:0] dec_pc,
    output opcode_t         dec_opcode,
    output reg_idx_t        dec_rd,
    output reg_idx_t        dec_rs1,
    output reg_idx_t        dec_rs2,
    output logic [xlen-1:0] dec_imm,
    output logic            dec_illegal
);

    logic            illegal;
    logic [xlen-1:0] imm_ext;

    // opcodes outside the defined set
    always_comb begin
        case (fetch_word.r_form.opcode)
            op_add, op_sub, op_xor, op_addi, op_beq, op_halt: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    // immediate through the i-form view
    assign imm_ext = {{(xlen-16){fetch_word.i_form.imm[15]}}, fetch_word.i_form.imm};

    //////////////////////////////////////////////////
    // decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    // decoded fields, register indices from the r-form view
    always_ff @(posedge clock) begin
        dec_pc      <= fetch_pc;
        dec_opcode  <= fetch_word.r_form.opcode;
        dec_rd      <= fetch_word.r_form.rd;
        dec_rs1     <= fetch_word.r_form.rs1;
        dec_rs2     <= fetch_word.r_form.rs2;
        dec_imm     <= imm_ext;
        dec_illegal <= illegal;
    end

endmodule

// File: fetch/stage_fetch.sv
module stage_fetch import cpu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  mem_tag_t        mem2proc_transaction_tag,
    input  logic [xlen-1:0] mem2proc_data,
    input  mem_tag_t        mem2proc_data_tag,
    input  logic            squash,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            halted,
    output mem_command_t    proc2mem_command,
    output logic [xlen-1:0] proc2mem_addr,
    output logic            fetch_valid,
    output logic [xlen-1:0] fetch_pc,
    output inst_word_t      fetch_word
);

    logic [1:0]      state;
    logic [xlen-1:0] pc;
    // tag of the single outstanding load
    mem_tag_t        pending_tag;
    // outstanding response belongs to a squashed path
    logic            discard;
    logic            issue;
    logic            accepted;
    logic            returned;

    // request only while not halted
    assign issue    = (state == fetch_requesting) && !halted;
    assign accepted = issue && (mem2proc_transaction_tag != '0);
    assign returned = (state == fetch_waiting) && (mem2proc_data_tag == pending_tag);

    assign proc2mem_command = issue ? mem_load : mem_none;
    assign proc2mem_addr    = pc;

    //////////////////////////////////////////////////
    // request FSM and pc
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= fetch_idle;
            pc          <= reset_pc;
            pending_tag <= '0;
            discard     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                fetch_idle: begin
                    if (!halted) begin
                        state <= fetch_requesting;
                    end
                end
                fetch_requesting: begin
                    // zero tag: same request again next cycle
                    if (accepted) begin
                        state       <= fetch_waiting;
                        pending_tag <= mem2proc_transaction_tag;
                        // a load issued during squash is for the old path
                        discard     <= squash;
                    end else if (halted) begin
                        state <= fetch_idle;
                    end
                end
                fetch_waiting: begin
                    if (returned) begin
                        state   <= fetch_requesting;
                        discard <= 1'b0;
                        if (!discard && !squash) begin
                            fetch_valid <= 1'b1;
                            pc          <= pc + 32'd4;
                        end
                    end else if (squash) begin
                        discard <= 1'b1;
                    end
                end
                default: state <= fetch_idle;
            endcase
            // redirect wins over the sequential advance
            if (squash) begin
                pc <= redirect_pc;
            end
        end
    end

    // fetched word and its address
    always_ff @(posedge clock) begin
        if (returned) begin
            fetch_pc   <= pc;
            fetch_word <= mem2proc_data;
        end
    end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

    //////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////

    // data and address width
    localparam int xlen = 32;
    // architectural registers
    localparam int reg_count = 8;
    // width of the retired instruction count port
    localparam int commit_cnt_width = 4;
    // first fetch address
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // fetch FSM encoding
    localparam logic [1:0] fetch_idle       = 2'd0;
    localparam logic [1:0] fetch_requesting = 2'd1;
    localparam logic [1:0] fetch_waiting    = 2'd2;

    typedef logic [2:0] reg_idx_t;

    // zero tag means the memory refused the request
    typedef logic [3:0] mem_tag_t;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mem_none = 2'h0,
        mem_load = 2'h1
    } mem_command_t;

    // values 6 to 15 are illegal
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_xor  = 4'h2,
        op_addi = 4'h3,
        op_beq  = 4'h4,
        op_halt = 4'h5
    } opcode_t;

    typedef enum logic [1:0] {
        no_error       = 2'h0,
        illegal_inst   = 2'h1,
        halted_on_halt = 2'h2
    } exception_code_t;

    // one instruction word, seen as register form or immediate form
    // beq uses rd and rs1 as the compared pair, imm as word offset
    typedef union packed {
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            reg_idx_t    rs2;
            logic [18:0] unused;
        } r_form;
        struct packed {
            opcode_t     opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            logic [5:0]  reserved;
            logic [15:0] imm;
        } i_form;
    } inst_word_t;

endpackage
